//--- common/lite_mux_consts.svh
`ifndef LITE_MUX_CONSTS_SVH
`define LITE_MUX_CONSTS_SVH

// Slave ports merged onto the one master port
`define LM_NUM_PORTS 4

// Outstanding reads, also the selection FIFO depth
`define LM_MAX_TRANS 4

// AXI4-Lite field widths
`define LM_ADDR_W 32
`define LM_DATA_W 32
`define LM_PROT_W 3
`define LM_RESP_W 2

`endif

//--- common/axi_lite_pkg.sv
`include "lite_mux_consts.svh"

package axi_lite_pkg;

  // Basic AXI4-Lite fields
  typedef logic [`LM_ADDR_W-1:0] addr_t;
  typedef logic [`LM_DATA_W-1:0] data_t;
  // Privileged, secure and instruction flags
  typedef logic [`LM_PROT_W-1:0] prot_t;
  // OKAY, EXOKAY, SLVERR, DECERR
  typedef logic [`LM_RESP_W-1:0] resp_t;

  // Read address channel payload
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  // Read data channel payload
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

endpackage

//--- common/mux_pkg.sv
`include "lite_mux_consts.svh"

package mux_pkg;

  // Index of one slave port
  typedef logic [$clog2(`LM_NUM_PORTS)-1:0] port_sel_t;
  // Selection FIFO fill level, must reach LM_MAX_TRANS
  typedef logic [$clog2(`LM_MAX_TRANS+1)-1:0] fifo_cnt_t;

endpackage

//--- common/ar_chan_if.sv
`timescale 1ns/1ps

interface ar_chan_if;
  import axi_lite_pkg::*;

  // Handshake
  logic  valid;
  logic  ready;
  // Payload, stable while valid waits for ready
  addr_t addr;
  prot_t prot;

  // Sender side
  modport src (
    output valid,
    output addr,
    output prot,
    input  ready
  );

  // Receiver side
  modport dst (
    input  valid,
    input  addr,
    input  prot,
    output ready
  );

endinterface

//--- src/rr_arbiter.sv
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module rr_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                [`LM_NUM_PORTS-1:0] req_valid_i,
  input  axi_lite_pkg::addr_t [`LM_NUM_PORTS-1:0] req_addr_i,
  input  axi_lite_pkg::prot_t [`LM_NUM_PORTS-1:0] req_prot_i,
  output logic                [`LM_NUM_PORTS-1:0] req_ready_o,
  ar_chan_if.src                                  ar_o,
  output mux_pkg::port_sel_t                      sel_o
);
  import mux_pkg::*;

  localparam int unsigned num_ports = `LM_NUM_PORTS;

  // Round-robin pointer, first port to look at
  port_sel_t rr_q;
  // Lock on an offered but not yet granted request
  logic      lock_q;
  port_sel_t lock_idx_q;
  // Search result and final choice
  port_sel_t found;
  port_sel_t sel;
  logic      xfer;

  // --------------------------------------------------
  // Port search
  // --------------------------------------------------
  // First valid port at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        hit;
    found = rr_q;
    hit   = 1'b0;
    for (int unsigned k = 0; k < num_ports; k++) begin
      idx = (int'(rr_q) + k) % num_ports;
      if (!hit && req_valid_i[idx]) begin
        found = port_sel_t'(idx);
        hit   = 1'b1;
      end
    end
  end

  // Locked index wins so valid and payload stay put
  assign sel = lock_q ? lock_idx_q : found;

  // Forward the chosen request
  assign ar_o.valid = req_valid_i[sel];
  assign ar_o.addr  = req_addr_i[sel];
  assign ar_o.prot  = req_prot_i[sel];
  assign sel_o      = sel;
  assign xfer       = ar_o.valid & ar_o.ready;

  // Grant only the chosen port, same cycle
  always_comb begin
    req_ready_o      = '0;
    req_ready_o[sel] = xfer;
  end

  // --------------------------------------------------
  // Pointer and lock state
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (xfer) begin
        // Step past the winner
        lock_q <= 1'b0;
        rr_q   <= (sel == port_sel_t'(num_ports - 1)) ? '0 : port_sel_t'(sel + 1'b1);
      end else if (ar_o.valid) begin
        // Offered, not taken
        lock_q <= 1'b1;
      end
      // Track the search while free
      if (!lock_q) begin
        lock_idx_q <= found;
      end
    end
  end

endmodule

//--- src/sel_fifo.sv
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module sel_fifo (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               push_i,
  input  mux_pkg::port_sel_t data_i,
  input  logic               pop_i,
  output mux_pkg::port_sel_t head_o,
  output logic               full_o,
  output logic               empty_o
);
  import mux_pkg::*;

  localparam int unsigned depth = `LM_MAX_TRANS;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  typedef logic [ptr_w-1:0] ptr_t;

  // Port indices of outstanding reads
  port_sel_t mem_q [depth];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  fifo_cnt_t cnt_q;
  logic      do_push;
  logic      do_pop;

  // Circular pointer step
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(depth - 1)) ? '0 : ptr_t'(p + 1'b1);
  endfunction

  // Flags off the registered count
  assign full_o  = (cnt_q == fifo_cnt_t'(depth));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign head_o  = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Push with pop leaves the count alone
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!do_push && do_pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- src/spill_register.sv
`timescale 1ns/1ps

module spill_register (
  input  logic   clk_i,
  input  logic   rst_n_i,
  ar_chan_if.dst in_i,
  ar_chan_if.src out_o
);
  import axi_lite_pkg::*;

  // Slot A takes input, slot B catches overflow
  ar_chan_t a_data_q;
  ar_chan_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  ar_chan_t in_data;
  ar_chan_t out_data;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  assign in_data = '{addr: in_i.addr, prot: in_i.prot};

  // --------------------------------------------------
  // Slot A
  // --------------------------------------------------
  assign a_fill  = in_i.valid & in_i.ready;
  // A empties whenever B is free
  assign a_drain = a_full_q & ~b_full_q;

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= in_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
    end else if (a_fill || a_drain) begin
      a_full_q <= a_fill;
    end
  end

  // --------------------------------------------------
  // Slot B
  // --------------------------------------------------
  // Catch A when the master stalls
  assign b_fill  = a_drain & ~out_o.ready;
  assign b_drain = b_full_q & out_o.ready;

  always_ff @(posedge clk_i) begin
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_full_q <= 1'b0;
    end else if (b_fill || b_drain) begin
      b_full_q <= b_fill;
    end
  end

  // Ready from flops only, no path from master ready
  assign in_i.ready  = ~a_full_q | ~b_full_q;
  // B is older, goes out first
  assign out_data    = b_full_q ? b_data_q : a_data_q;
  assign out_o.valid = a_full_q | b_full_q;
  assign out_o.addr  = out_data.addr;
  assign out_o.prot  = out_data.prot;

endmodule

//--- mux/r_router.sv
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module r_router (
  input  mux_pkg::port_sel_t                      sel_i,
  input  logic                                    empty_i,
  output logic                                    pop_o,
  input  logic                                    mst_r_valid_i,
  input  axi_lite_pkg::data_t                     mst_r_data_i,
  input  axi_lite_pkg::resp_t                     mst_r_resp_i,
  output logic                                    mst_r_ready_o,
  output logic                [`LM_NUM_PORTS-1:0] slv_r_valid_o,
  output axi_lite_pkg::data_t [`LM_NUM_PORTS-1:0] slv_r_data_o,
  output axi_lite_pkg::resp_t [`LM_NUM_PORTS-1:0] slv_r_resp_o,
  input  logic                [`LM_NUM_PORTS-1:0] slv_r_ready_i
);
  import axi_lite_pkg::*;
  import mux_pkg::*;

  r_chan_t r_chan;
  // Some read outstanding
  logic    active;

  assign r_chan = '{data: mst_r_data_i, resp: mst_r_resp_i};
  assign active = ~empty_i;

  // Payload fans out, valid only to FIFO head port
  for (genvar i = 0; i < `LM_NUM_PORTS; i++) begin : gen_slv_r
    assign slv_r_data_o[i]  = r_chan.data;
    assign slv_r_resp_o[i]  = r_chan.resp;
    assign slv_r_valid_o[i] = mst_r_valid_i & active & (sel_i == port_sel_t'(i));
  end

  // Back-pressure from the head port only
  assign mst_r_ready_o = active & slv_r_ready_i[sel_i];
  // Response done, next outstanding read
  assign pop_o         = mst_r_valid_i & mst_r_ready_o;

endmodule

//--- mux/lite_rd_mux.sv
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module lite_rd_mux (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Slave AR
  input  logic                [`LM_NUM_PORTS-1:0] slv_ar_valid_i,
  input  axi_lite_pkg::addr_t [`LM_NUM_PORTS-1:0] slv_ar_addr_i,
  input  axi_lite_pkg::prot_t [`LM_NUM_PORTS-1:0] slv_ar_prot_i,
  output logic                [`LM_NUM_PORTS-1:0] slv_ar_ready_o,
  // Slave R
  output logic                [`LM_NUM_PORTS-1:0] slv_r_valid_o,
  output axi_lite_pkg::data_t [`LM_NUM_PORTS-1:0] slv_r_data_o,
  output axi_lite_pkg::resp_t [`LM_NUM_PORTS-1:0] slv_r_resp_o,
  input  logic                [`LM_NUM_PORTS-1:0] slv_r_ready_i,
  // Master AR
  output logic                                    mst_ar_valid_o,
  output axi_lite_pkg::addr_t                     mst_ar_addr_o,
  output axi_lite_pkg::prot_t                     mst_ar_prot_o,
  input  logic                                    mst_ar_ready_i,
  // Master R
  input  logic                                    mst_r_valid_i,
  input  axi_lite_pkg::data_t                     mst_r_data_i,
  input  axi_lite_pkg::resp_t                     mst_r_resp_i,
  output logic                                    mst_r_ready_o
);
  import mux_pkg::*;

  // Arbiter to spill register, spill register to master
  ar_chan_if arb_ar ();
  ar_chan_if mst_ar ();

  logic [`LM_NUM_PORTS-1:0] arb_req_valid;
  port_sel_t                ar_sel;
  port_sel_t                r_sel;
  logic                     fifo_full;
  logic                     fifo_empty;
  logic                     fifo_push;
  logic                     fifo_pop;

  // --------------------------------------------------
  // AR arbitration
  // --------------------------------------------------
  // Requests hidden while the FIFO is full
  // Lock cannot be held then, full rises only on a transfer
  assign arb_req_valid = slv_ar_valid_i & {`LM_NUM_PORTS{~fifo_full}};

  rr_arbiter i_rr_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (arb_req_valid),
    .req_addr_i  (slv_ar_addr_i),
    .req_prot_i  (slv_ar_prot_i),
    .req_ready_o (slv_ar_ready_o),
    .ar_o        (arb_ar),
    .sel_o       (ar_sel)
  );

  // Record the winner on every accepted AR
  assign fifo_push = arb_ar.valid & arb_ar.ready;

  sel_fifo i_sel_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (fifo_push),
    .data_i  (ar_sel),
    .pop_i   (fifo_pop),
    .head_o  (r_sel),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // One cycle to the master port
  spill_register i_ar_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .in_i    (arb_ar),
    .out_o   (mst_ar)
  );

  assign mst_ar_valid_o = mst_ar.valid;
  assign mst_ar_addr_o  = mst_ar.addr;
  assign mst_ar_prot_o  = mst_ar.prot;
  assign mst_ar.ready   = mst_ar_ready_i;

  // --------------------------------------------------
  // R routing, in order
  // --------------------------------------------------
  r_router i_r_router (
    .sel_i         (r_sel),
    .empty_i       (fifo_empty),
    .pop_o         (fifo_pop),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_resp_i  (mst_r_resp_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_resp_o  (slv_r_resp_o),
    .slv_r_ready_i (slv_r_ready_i)
  );

endmodule

//--- tb/lite_rd_mux_sva.sv
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module lite_rd_mux_sva (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    mst_ar_valid_i,
  input  axi_lite_pkg::addr_t                     mst_ar_addr_i,
  input  axi_lite_pkg::prot_t                     mst_ar_prot_i,
  input  logic                                    mst_ar_ready_i,
  input  logic                [`LM_NUM_PORTS-1:0] slv_r_valid_i,
  input  logic                                    mst_r_valid_i,
  input  logic                                    mst_r_ready_i
);

  // Master AR accepted but R not yet returned
  int unsigned outstanding_q;
  logic        ar_xfer;
  logic        r_xfer;

  assign ar_xfer = mst_ar_valid_i & mst_ar_ready_i;
  assign r_xfer  = mst_r_valid_i & mst_r_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 0;
    end else if (ar_xfer && !r_xfer) begin
      outstanding_q <= outstanding_q + 1;
    end else if (!ar_xfer && r_xfer) begin
      outstanding_q <= outstanding_q - 1;
    end
  end

  // AXI stability rule on the master AR port
  ar_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_i && !mst_ar_ready_i |=>
      mst_ar_valid_i && $stable(mst_ar_addr_i) && $stable(mst_ar_prot_i))
    else $error("Master AR dropped or changed before ready");

  // Only the FIFO head port may see R valid
  r_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(slv_r_valid_i))
    else $error("More than one slave R valid at once");

  outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding_q <= `LM_MAX_TRANS)
    else $error("Master side outstanding reads above limit");

endmodule

bind lite_rd_mux lite_rd_mux_sva i_lite_rd_mux_sva (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .mst_ar_valid_i (mst_ar_valid_o),
  .mst_ar_addr_i  (mst_ar_addr_o),
  .mst_ar_prot_i  (mst_ar_prot_o),
  .mst_ar_ready_i (mst_ar_ready_i),
  .slv_r_valid_i  (slv_r_valid_o),
  .mst_r_valid_i  (mst_r_valid_i),
  .mst_r_ready_i  (mst_r_ready_o)
);

//--- tb/lite_rd_mux_checker.sv
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module lite_rd_mux_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    idle_chk_i,
  input  logic                                    fair_chk_i,
  input  logic                [`LM_NUM_PORTS-1:0] slv_ar_valid_i,
  input  axi_lite_pkg::addr_t [`LM_NUM_PORTS-1:0] slv_ar_addr_i,
  input  axi_lite_pkg::prot_t [`LM_NUM_PORTS-1:0] slv_ar_prot_i,
  input  logic                [`LM_NUM_PORTS-1:0] slv_ar_ready_i,
  input  logic                [`LM_NUM_PORTS-1:0] slv_r_valid_i,
  input  axi_lite_pkg::data_t [`LM_NUM_PORTS-1:0] slv_r_data_i,
  input  axi_lite_pkg::resp_t [`LM_NUM_PORTS-1:0] slv_r_resp_i,
  input  logic                [`LM_NUM_PORTS-1:0] slv_r_ready_i,
  input  logic                                    mst_ar_valid_i,
  input  axi_lite_pkg::addr_t                     mst_ar_addr_i,
  input  axi_lite_pkg::prot_t                     mst_ar_prot_i,
  input  logic                                    mst_ar_ready_i,
  input  logic                                    mst_r_valid_i,
  input  logic                                    mst_r_ready_i,
  output int unsigned                             err_cnt_o,
  output int unsigned                             rd_cnt_o,
  output int unsigned                             pending_o
);
  import axi_lite_pkg::*;

  localparam int unsigned num_ports = `LM_NUM_PORTS;

  // Accepted addresses per port, in issue order
  addr_t                exp_q [num_ports][$];
  // Accepted AR payloads of all ports, in grant order
  ar_chan_t             ar_exp_q [$];
  // R held valid without ready last cycle
  logic [num_ports-1:0] hold_q;
  data_t                hold_data_q [num_ports];
  resp_t                hold_resp_q [num_ports];
  // Ports granted in the current round
  logic [num_ports-1:0] seen_q;
  int                   mst_out;

  always @(posedge clk_i) begin
    addr_t    a;
    resp_t    exp_resp;
    ar_chan_t ar_exp;
    if (!rst_n_i) begin
      for (int p = 0; p < num_ports; p++) begin
        exp_q[p].delete();
      end
      ar_exp_q.delete();
      hold_q    = '0;
      seen_q    = '0;
      mst_out   = 0;
      err_cnt_o = 0;
      rd_cnt_o  = 0;
      pending_o = 0;
    end else begin
      if (idle_chk_i && (mst_ar_valid_i || (|slv_r_valid_i))) begin
        $display("[FAIL] %0t valid raised on an idle DUT", $time);
        err_cnt_o++;
      end
      // Master side outstanding count
      if (mst_ar_valid_i && mst_ar_ready_i) mst_out++;
      if (mst_r_valid_i && mst_r_ready_i) mst_out--;
      if (mst_out > `LM_MAX_TRANS) begin
        $display("More than %0d reads outstanding on the master port", `LM_MAX_TRANS);
        err_cnt_o++;
      end
      // ---- AR forwarded to the master, grant order kept
      if (mst_ar_valid_i && mst_ar_ready_i) begin
        if (ar_exp_q.size() == 0) begin
          $display("Master AR issued with no slave request accepted");
          err_cnt_o++;
        end else begin
          ar_exp = ar_exp_q.pop_front();
          if (mst_ar_addr_i != ar_exp.addr || mst_ar_prot_i != ar_exp.prot) begin
            $display("[FAIL] %0t master AR got %h/%0d, expected %h/%0d", $time,
                     mst_ar_addr_i, mst_ar_prot_i, ar_exp.addr, ar_exp.prot);
            err_cnt_o++;
          end
        end
      end
      if (!fair_chk_i) seen_q = '0;
      for (int p = 0; p < num_ports; p++) begin
        // ---- AR accepted on port p
        if (slv_ar_valid_i[p] && slv_ar_ready_i[p]) begin
          exp_q[p].push_back(slv_ar_addr_i[p]);
          ar_exp.addr = slv_ar_addr_i[p];
          ar_exp.prot = slv_ar_prot_i[p];
          ar_exp_q.push_back(ar_exp);
          pending_o++;
          if (fair_chk_i) begin
            if (seen_q[p] && (|(~seen_q & slv_ar_valid_i))) begin
              $display("Port %0d granted twice before other waiting ports", p);
              err_cnt_o++;
            end
            if (seen_q[p]) seen_q = '0;
            seen_q[p] = 1'b1;
          end
        end
        // ---- R on port p
        if (slv_r_valid_i[p]) begin
          if (hold_q[p] && (slv_r_data_i[p] != hold_data_q[p] ||
                            slv_r_resp_i[p] != hold_resp_q[p])) begin
            $display("[FAIL] %0t port %0d R payload changed before ready", $time, p);
            err_cnt_o++;
          end
          if (slv_r_ready_i[p]) begin
            if (exp_q[p].size() == 0) begin
              $display("Port %0d got an R response with no read outstanding", p);
              err_cnt_o++;
            end else begin
              a        = exp_q[p].pop_front();
              exp_resp = a[31] ? resp_t'(2) : resp_t'(0);
              pending_o--;
              rd_cnt_o++;
              if (slv_r_data_i[p] != ~a || slv_r_resp_i[p] != exp_resp) begin
                $display("[FAIL] %0t port %0d got %h/%0d, expected %h/%0d", $time, p,
                         slv_r_data_i[p], slv_r_resp_i[p], ~a, exp_resp);
                err_cnt_o++;
              end
            end
          end
        end else if (hold_q[p]) begin
          $display("Port %0d dropped R valid before ready", p);
          err_cnt_o++;
        end
        hold_q[p]      = slv_r_valid_i[p] & ~slv_r_ready_i[p];
        hold_data_q[p] = slv_r_data_i[p];
        hold_resp_q[p] = slv_r_resp_i[p];
      end
    end
  end

endmodule

//--- tb/tb_lite_rd_mux.sv
`timescale 1ns/1ps
`include "lite_mux_consts.svh"

module tb_lite_rd_mux;
  import axi_lite_pkg::*;

  localparam int unsigned num_ports = `LM_NUM_PORTS;
  localparam int unsigned num_tests = 6;

  logic                      clk;
  logic                      rst_n;
  logic  [num_ports-1:0]     slv_ar_valid;
  addr_t [num_ports-1:0]     slv_ar_addr;
  prot_t [num_ports-1:0]     slv_ar_prot;
  logic  [num_ports-1:0]     slv_ar_ready;
  logic  [num_ports-1:0]     slv_r_valid;
  data_t [num_ports-1:0]     slv_r_data;
  resp_t [num_ports-1:0]     slv_r_resp;
  logic  [num_ports-1:0]     slv_r_ready;
  logic                      mst_ar_valid;
  addr_t                     mst_ar_addr;
  prot_t                     mst_ar_prot;
  logic                      mst_ar_ready;
  logic                      mst_r_valid;
  data_t                     mst_r_data;
  resp_t                     mst_r_resp;
  logic                      mst_r_ready;

  // Stimulus knobs, rates in percent
  logic [num_ports-1:0] port_en;
  int unsigned          ar_rate;
  int unsigned          r_rdy_rate;
  int unsigned          mst_ar_rate;
  int unsigned          gap_max;
  int unsigned          quota;
  logic                 r_en;
  logic                 idle_chk;
  logic                 fair_chk;
  int unsigned          issued [num_ports];
  // Handshakes seen at the last rising edge
  logic [num_ports-1:0] ar_acc;
  logic                 mst_r_acc;
  // Memory responder read queue
  addr_t                mem_q [$];
  int unsigned          gap;
  int unsigned          err_cnt;
  int unsigned          rd_cnt;
  int unsigned          pending;
  logic                 timed_out;
  string test_names [num_tests] = '{"idle", "single", "concurrent", "fairness",
                                    "hold_off", "r_backpressure"};

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  lite_rd_mux i_lite_rd_mux (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_addr_i  (slv_ar_addr),
    .slv_ar_prot_i  (slv_ar_prot),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_data_o   (slv_r_data),
    .slv_r_resp_o   (slv_r_resp),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_addr_o  (mst_ar_addr),
    .mst_ar_prot_o  (mst_ar_prot),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_data_i   (mst_r_data),
    .mst_r_resp_i   (mst_r_resp),
    .mst_r_ready_o  (mst_r_ready)
  );

  lite_rd_mux_checker i_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .idle_chk_i     (idle_chk),
    .fair_chk_i     (fair_chk),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_addr_i  (slv_ar_addr),
    .slv_ar_prot_i  (slv_ar_prot),
    .slv_ar_ready_i (slv_ar_ready),
    .slv_r_valid_i  (slv_r_valid),
    .slv_r_data_i   (slv_r_data),
    .slv_r_resp_i   (slv_r_resp),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_valid_i (mst_ar_valid),
    .mst_ar_addr_i  (mst_ar_addr),
    .mst_ar_prot_i  (mst_ar_prot),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_i  (mst_r_ready),
    .err_cnt_o      (err_cnt),
    .rd_cnt_o       (rd_cnt),
    .pending_o      (pending)
  );

  // --------------------------------------------------
  // Edge sampling and memory behind the master port
  // --------------------------------------------------
  always @(posedge clk) begin
    ar_acc    <= slv_ar_valid & slv_ar_ready;
    mst_r_acc <= mst_r_valid & mst_r_ready;
    if (mst_ar_valid && mst_ar_ready) mem_q.push_back(mst_ar_addr);
  end

  // All DUT inputs change on the falling edge
  always @(negedge clk) begin
    addr_t a;
    if (rst_n) begin
      for (int p = 0; p < num_ports; p++) begin
        // New request only once the old one was taken
        if (!slv_ar_valid[p] || ar_acc[p]) begin
          if (port_en[p] && issued[p] < quota && $urandom_range(99) < ar_rate) begin
            slv_ar_valid[p] = 1'b1;
            slv_ar_addr[p]  = $urandom();
            slv_ar_prot[p]  = prot_t'($urandom_range(7));
            issued[p]       = issued[p] + 1;
          end else begin
            slv_ar_valid[p] = 1'b0;
          end
        end
        slv_r_ready[p] = ($urandom_range(99) < r_rdy_rate);
      end
      mst_ar_ready = ($urandom_range(99) < mst_ar_rate);
      // In-order responder with a random gap
      if (mst_r_valid && mst_r_acc) begin
        mst_r_valid = 1'b0;
        gap         = $urandom_range(gap_max);
      end
      if (!mst_r_valid && r_en && mem_q.size() != 0) begin
        if (gap != 0) begin
          gap--;
        end else begin
          a           = mem_q.pop_front();
          mst_r_valid = 1'b1;
          mst_r_data  = ~a;
          mst_r_resp  = a[31] ? resp_t'(2) : resp_t'(0);
        end
      end
    end
  end

  // --------------------------------------------------
  // Sequencing helpers
  // --------------------------------------------------
  // Just past the rising edge, all values settled
  task automatic step(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_issued(input int unsigned limit);
    int unsigned n;
    logic        done;
    n    = 0;
    done = 1'b0;
    while (!done && !timed_out) begin
      step(1);
      n++;
      done = 1'b1;
      for (int p = 0; p < num_ports; p++) begin
        if (port_en[p] && (issued[p] < quota || slv_ar_valid[p])) done = 1'b0;
      end
      if (!done && n >= limit) begin
        $display("Timeout: slave requests not all accepted in %0d cycles", limit);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_drain(input int unsigned limit);
    int unsigned n;
    logic        done;
    n    = 0;
    done = 1'b0;
    while (!done && !timed_out) begin
      step(1);
      n++;
      done = (pending == 0) && (mem_q.size() == 0) && !mst_r_valid && !mst_ar_valid;
      if (!done && n >= limit) begin
        $display("Timeout: %0d reads never returned in %0d cycles", pending, limit);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic run_test(input int id);
    port_en     = '1;
    ar_rate     = 50;
    r_rdy_rate  = 60;
    mst_ar_rate = 60;
    gap_max     = 4;
    quota       = 30;
    r_en        = 1'b1;
    for (int p = 0; p < num_ports; p++) begin
      issued[p] = 0;
    end
    case (id)
      0: begin
        port_en  = '0;
        quota    = 0;
        idle_chk = 1'b1;
      end
      1: begin
        port_en = '0;
        port_en[$urandom_range(num_ports - 1)] = 1'b1;
        ar_rate = 70;
        quota   = 20;
      end
      3: begin
        // Continuous requests, no back-pressure
        ar_rate     = 100;
        r_rdy_rate  = 100;
        mst_ar_rate = 100;
        gap_max     = 0;
        quota       = 25;
        fair_chk    = 1'b1;
      end
      4: begin
        ar_rate = 80;
        quota   = 20;
      end
      5: begin
        r_rdy_rate = 20;
        quota      = 15;
      end
      default: begin
      end
    endcase
    if (id == 0) step(30);
    if (id == 4) begin
      // Master AR stalled, then the responder silent
      mst_ar_rate = 0;
      step(100);
      mst_ar_rate = 70;
      r_en        = 1'b0;
      step(100);
      r_en = 1'b1;
    end
    wait_issued(5000);
    wait_drain(2000);
    idle_chk = 1'b0;
    fair_chk = 1'b0;
    port_en  = '0;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int unsigned err_before;
    int unsigned rd_before;
    int unsigned tests_failed;
    void'($urandom(32'h60d9_8d82));
    rst_n        = 1'b0;
    slv_ar_valid = '0;
    slv_ar_addr  = '0;
    slv_ar_prot  = '0;
    slv_r_ready  = '0;
    mst_ar_ready = 1'b0;
    mst_r_valid  = 1'b0;
    mst_r_data   = '0;
    mst_r_resp   = '0;
    port_en      = '0;
    ar_rate      = 0;
    r_rdy_rate   = 0;
    mst_ar_rate  = 0;
    gap_max      = 0;
    quota        = 0;
    r_en         = 1'b0;
    idle_chk     = 1'b0;
    fair_chk     = 1'b0;
    gap          = 0;
    timed_out    = 1'b0;
    tests_failed = 0;
    for (int p = 0; p < num_ports; p++) begin
      issued[p] = 0;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    step(2);
    for (int t = 0; t < num_tests; t++) begin
      if (!timed_out) begin
        err_before = err_cnt;
        rd_before  = rd_cnt;
        run_test(t);
        if (timed_out || err_cnt != err_before) tests_failed++;
        $display("test %0d %s: %0d reads, %0d errors", t, test_names[t],
                 rd_cnt - rd_before, err_cnt - err_before);
      end
    end
    $display("tests %0d, failed %0d, reads %0d, errors %0d", num_tests, tests_failed,
             rd_cnt, err_cnt);
    if (timed_out || err_cnt != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+common
common/axi_lite_pkg.sv
common/mux_pkg.sv
common/ar_chan_if.sv
src/rr_arbiter.sv
src/sel_fifo.sv
src/spill_register.sv
mux/r_router.sv
mux/lite_rd_mux.sv
tb/lite_rd_mux_sva.sv
tb/lite_rd_mux_checker.sv
tb/tb_lite_rd_mux.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_lite_rd_mux -f src.f \
  -o tb_lite_rd_mux &&
./obj_dir/tb_lite_rd_mux > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
